// File: build.f
+incdir+include
hdl/sqrt_fmt_pkg.sv
hdl/cordic_pkg.sv
hdl/sqrt_prescale.sv
hdl/hyperbolic_stage.sv
hdl/cordic_pipeline.sv
hdl/gain_correct.sv
hdl/cordic_sqrt_top.sv
tb/tb_cordic_sqrt.sv

// File: include/sqrt_ref_model.svh
`ifndef SQRT_REF_MODEL_SVH
`define SQRT_REF_MODEL_SVH

// bit-exact model of cordic_sqrt_top with the same widths and wrap behaviour
function automatic sqrt_fmt_pkg::out_t sqrt_ref(input sqrt_fmt_pkg::in_t v,
                                                input int num_iter);
  sqrt_fmt_pkg::work_t x;
  sqrt_fmt_pkg::work_t y;
  sqrt_fmt_pkg::work_t xs;
  sqrt_fmt_pkg::work_t ys;
  sqrt_fmt_pkg::work_t widened;
  sqrt_fmt_pkg::work_t quarter;
  logic signed [32:0]  prod;
  logic signed [32:0]  scaled;
  int                  reps;
  widened = sqrt_fmt_pkg::work_t'(v) << (sqrt_fmt_pkg::WORK_FRAC - sqrt_fmt_pkg::IN_FRAC);
  quarter = sqrt_fmt_pkg::work_t'(1) << (sqrt_fmt_pkg::WORK_FRAC - 2);
  x = widened + quarter;
  y = widened - quarter;
  for (int i = 1; i <= num_iter; i++) begin
    reps = cordic_pkg::is_repeat_iter(i) ? 2 : 1;
    for (int r = 0; r < reps; r++) begin
      xs = x >>> i;  // both shifts taken before either update
      ys = y >>> i;
      if (y < 0) begin
        x = x + ys;
        y = y + xs;
      end else begin
        x = x - ys;
        y = y - xs;
      end
    end
  end
  prod = x * $signed({1'b0, cordic_pkg::GAIN_INV});
  scaled = prod >>> (cordic_pkg::GAIN_FRAC + sqrt_fmt_pkg::WORK_FRAC - sqrt_fmt_pkg::IN_FRAC);
  if (scaled < 0) begin
    return '0;
  end else if (scaled > ((1 << sqrt_fmt_pkg::IN_WIDTH) - 1)) begin
    return '1;
  end
  return scaled[sqrt_fmt_pkg::IN_WIDTH-1:0];
endfunction

// true root of an input code, truncated to IN_FRAC bits, as an output code
function automatic int sqrt_true_code(input sqrt_fmt_pkg::in_t v);
  real value;
  real root;
  value = real'(v) / real'(1 << sqrt_fmt_pkg::IN_FRAC);
  root = $sqrt(value) * real'(1 << sqrt_fmt_pkg::IN_FRAC);
  return int'($floor(root));
endfunction

// 32-bit xorshift whose state must never be zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] t;
  t = s;
  t = t ^ (t << 13);
  t = t ^ (t >> 17);
  t = t ^ (t << 5);
  return t;
endfunction

`endif

// File: tb/tb_cordic_sqrt.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the pipelined CORDIC square root
module tb_cordic_sqrt;

  localparam int NUM_ITER = cordic_pkg::NUM_ITER_DEFAULT;
  localparam int LATENCY = NUM_ITER + 2;  // sample edge to the edge that sees out_valid
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 4;
  localparam int QUIET_CYCLES = 2 * LATENCY;
  localparam int NUM_CODES = 1 << sqrt_fmt_pkg::IN_WIDTH;
  localparam int RAND_CYCLES = 300;

  // convergence domain 0.25 .. 2.0 as input codes
  localparam int DOMAIN_LO = (1 << sqrt_fmt_pkg::IN_FRAC) / 4;
  localparam int DOMAIN_HI = 2 << sqrt_fmt_pkg::IN_FRAC;

  // every stimulus cycle, each drain wait and the final idle stretch
  localparam int STIM_CYCLES = RESET_CYCLES + QUIET_CYCLES + 1 + NUM_CODES + RAND_CYCLES;
  localparam int DRAIN_CYCLES = 4 * (LATENCY + 1);
  localparam int WATCHDOG_CYCLES = STIM_CYCLES + DRAIN_CYCLES + NUM_ITER + 20;

  `include "sqrt_ref_model.svh"

  // one accepted input waiting for its result
  typedef struct packed {
    logic [31:0]        sample_edge;
    sqrt_fmt_pkg::in_t  code;
    sqrt_fmt_pkg::out_t expected;
  } pending_t;

  logic               clk = 1'b0;
  logic               rst;
  logic               in_valid;
  sqrt_fmt_pkg::in_t  in_data;
  logic               out_valid;
  sqrt_fmt_pkg::out_t out_data;

  logic [31:0] edge_cnt = '0;  // rising edges seen so far
  logic [31:0] rng_state;
  pending_t    pend_q[$];

  cordic_sqrt_top #(
    .NUM_ITER(NUM_ITER)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_data (out_data)
  );

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR @ %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // drive one cycle on the falling edge and queue the expected result
  task automatic send(input logic valid, input sqrt_fmt_pkg::in_t data);
    pending_t item;
    @(negedge clk);
    in_valid = valid;
    in_data = data;
    if (valid) begin
      item.sample_edge = edge_cnt + 1;  // sampled on the coming rising edge
      item.code = data;
      item.expected = sqrt_ref(data, NUM_ITER);
      pend_q.push_back(item);
    end
  endtask

  // idle until every queued input has come out or the pipeline must be empty
  task automatic drain();
    int waited;
    waited = 0;
    send(1'b0, '0);
    while (pend_q.size() != 0 && waited < LATENCY + 1) begin
      @(negedge clk);
      waited++;
    end
  endtask

  // compare on the falling edge where outputs are settled
  always @(negedge clk) begin : compare
    pending_t item;
    int       true_code;
    int       diff;
    if (rst) begin
      check_value(out_valid, 1'b0, "out_valid during reset");
    end else if (out_valid === 1'b1) begin
      if (pend_q.size() == 0) begin
        $display("output at %0t with no input waiting for it", $time);
        stop_on_failure();
      end else begin
        item = pend_q.pop_front();
        check_value(out_data, item.expected, $sformatf("root of code %0d", item.code));
        // out_valid is seen by the coming rising edge
        check_value(edge_cnt + 1 - item.sample_edge, LATENCY, "latency in cycles");
        if (item.code >= DOMAIN_LO && item.code <= DOMAIN_HI) begin
          true_code = sqrt_true_code(item.code);
          diff = int'(out_data) - true_code;
          if (diff > 1 || diff < -1) begin
            check_value(out_data, true_code, $sformatf("accuracy for code %0d", item.code));
          end
        end
      end
    end else begin
      check_value(out_valid, 1'b0, "out_valid while idle");
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, results still missing", WATCHDOG_CYCLES);
    stop_on_failure();
  end

  initial begin : stimulus
    rst = 1'b1;
    in_valid = 1'b1;  // held valid through reset and expected to be dropped
    in_data = 8'h40;
    rng_state = 32'd18;

    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      in_data = sqrt_fmt_pkg::in_t'(8'h40 + 8'(i));
    end
    rst = 1'b0;
    in_valid = 1'b0;
    in_data = '0;

    // nothing may come out before the first real input
    repeat (QUIET_CYCLES) @(negedge clk);

    send(1'b1, 8'd32);  // isolated input of 4.0
    drain();

    for (int c = 0; c < NUM_CODES; c++) begin
      send(1'b1, sqrt_fmt_pkg::in_t'(c));  // back to back
    end
    drain();

    for (int i = 0; i < RAND_CYCLES; i++) begin
      rng_state = xorshift32(rng_state);
      send(rng_state[4], rng_state[23:16]);
    end
    drain();

    repeat (LATENCY) @(negedge clk);  // no stray outputs after the last one

    if (pend_q.size() != 0) begin
      $display("%0d inputs never produced an output", pend_q.size());
      stop_on_failure();
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cordic_sqrt_top.sv
`timescale 1ns/1ps
`default_nettype none

// pipelined hyperbolic CORDIC square root
// latency NUM_ITER + 2 cycles, one sample per cycle, no back-pressure
module cordic_sqrt_top #(
  parameter int NUM_ITER = cordic_pkg::NUM_ITER_DEFAULT
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               in_valid,
  input  wire sqrt_fmt_pkg::in_t  in_data,
  output      logic               out_valid,
  output      sqrt_fmt_pkg::out_t out_data
);

  cordic_pkg::cordic_beat_t start_beat;  // prescale -> pipeline
  cordic_pkg::cordic_beat_t final_beat;  // pipeline -> gain correction

  sqrt_prescale u_prescale (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .in_data (in_data),
    .beat    (start_beat)
  );

  cordic_pipeline #(
    .NUM_ITER(NUM_ITER)
  ) u_pipeline (
    .clk     (clk),
    .rst     (rst),
    .beat_in (start_beat),
    .beat_out(final_beat)
  );

  gain_correct u_gain (
    .clk      (clk),
    .rst      (rst),
    .beat_in  (final_beat),
    .out_valid(out_valid),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// File: hdl/gain_correct.sv
`timescale 1ns/1ps
`default_nettype none

// removes the CORDIC gain from x and brings the root back to the input format
module gain_correct (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire cordic_pkg::cordic_beat_t beat_in,
  output      logic                     out_valid,
  output      sqrt_fmt_pkg::out_t       out_data
);

  // signed product of x and the unsigned gain with a zero sign bit added
  localparam int PROD_W = sqrt_fmt_pkg::WORK_WIDTH + $bits(cordic_pkg::GAIN_INV) + 1;

  // drop gain and work fraction bits, keep IN_FRAC of them
  localparam int PROD_SHIFT =
    cordic_pkg::GAIN_FRAC + sqrt_fmt_pkg::WORK_FRAC - sqrt_fmt_pkg::IN_FRAC;

  localparam int OUT_MAX = (1 << sqrt_fmt_pkg::IN_WIDTH) - 1;

  sqrt_fmt_pkg::work_t        x_in;
  logic signed [PROD_W-1:0]   prod;
  logic signed [PROD_W-1:0]   scaled;
  sqrt_fmt_pkg::out_t         clamped;

  always_comb begin
    x_in = beat_in.x;
    prod = x_in * $signed({1'b0, cordic_pkg::GAIN_INV});
    scaled = prod >>> PROD_SHIFT;  // floor toward minus infinity

    // x can go negative or overrange outside the convergence domain
    if (scaled < 0) begin
      clamped = '0;
    end else if (scaled > OUT_MAX) begin
      clamped = '1;
    end else begin
      clamped = scaled[sqrt_fmt_pkg::IN_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= beat_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    out_data <= clamped;
  end

endmodule

`default_nettype wire

// File: hdl/cordic_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

// chain of NUM_ITER registered iterations, shift 1 first
module cordic_pipeline #(
  parameter int NUM_ITER = 10
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire cordic_pkg::cordic_beat_t beat_in,
  output      cordic_pkg::cordic_beat_t beat_out
);

  // beats[i] is the output of iteration i, beats[0] the pipeline input
  cordic_pkg::cordic_beat_t beats [0:NUM_ITER];

  assign beats[0] = beat_in;

  for (genvar i = 1; i <= NUM_ITER; i++) begin : g_stage
    hyperbolic_stage #(
      .SHIFT(i)
    ) u_stage (
      .clk     (clk),
      .rst     (rst),
      .beat_in (beats[i-1]),
      .beat_out(beats[i])
    );
  end

  assign beat_out = beats[NUM_ITER];

endmodule

`default_nettype wire

// File: hdl/hyperbolic_stage.sv
`timescale 1ns/1ps
`default_nettype none

// one registered hyperbolic CORDIC iteration in vectoring mode
// drives y toward zero while x picks up the scaled root
module hyperbolic_stage #(
  parameter int SHIFT = 1  // iteration index, also the shift amount
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire cordic_pkg::cordic_beat_t beat_in,
  output      cordic_pkg::cordic_beat_t beat_out
);

  // set when this index belongs to the repeat sequence
  localparam bit REPEAT = cordic_pkg::is_repeat_iter(SHIFT);

  // single shift-add step with the valid bit passed through
  function automatic cordic_pkg::cordic_beat_t rotate(input cordic_pkg::cordic_beat_t b);
    cordic_pkg::cordic_beat_t r;
    sqrt_fmt_pkg::work_t      xs;
    sqrt_fmt_pkg::work_t      ys;
    xs = b.x;
    ys = b.y;
    r = b;
    if (ys < 0) begin
      r.x = xs + (ys >>> SHIFT);
      r.y = ys + (xs >>> SHIFT);
    end else begin
      r.x = xs - (ys >>> SHIFT);
      r.y = ys - (xs >>> SHIFT);
    end
    return r;
  endfunction

  cordic_pkg::cordic_beat_t first;
  cordic_pkg::cordic_beat_t next;

  always_comb begin
    first = rotate(beat_in);
    if (REPEAT) begin
      next = rotate(first);  // second pass at the same shift
    end else begin
      next = first;
    end
  end

  always_ff @(posedge clk) begin
    beat_out <= next;
    if (rst) begin
      beat_out.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sqrt_prescale.sv
`timescale 1ns/1ps
`default_nettype none

// moves the sample into the work format and forms the starting pair
// x = v + 1/4, y = v - 1/4, so that x^2 - y^2 = v
module sqrt_prescale (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     in_valid,
  input  wire sqrt_fmt_pkg::in_t        in_data,
  output      cordic_pkg::cordic_beat_t beat
);

  localparam int ALIGN = sqrt_fmt_pkg::WORK_FRAC - sqrt_fmt_pkg::IN_FRAC;

  // one quarter in the work format
  localparam sqrt_fmt_pkg::work_t QUARTER =
    sqrt_fmt_pkg::work_t'(1) << (sqrt_fmt_pkg::WORK_FRAC - 2);

  sqrt_fmt_pkg::work_t      widened;
  cordic_pkg::cordic_beat_t start;

  always_comb begin
    // top integer bits fall off for inputs of 8.0 and above
    widened = sqrt_fmt_pkg::work_t'(in_data) << ALIGN;
    start.valid = in_valid;
    start.x = widened + QUARTER;
    start.y = widened - QUARTER;
  end

  always_ff @(posedge clk) begin
    beat <= start;
    if (rst) begin
      beat.valid <= 1'b0;  // only the strobe is cleared
    end
  end

endmodule

`default_nettype wire

// File: hdl/cordic_pkg.sv
`default_nettype none

// hyperbolic CORDIC constants and the beat passed from stage to stage
package cordic_pkg;

  localparam int NUM_ITER_DEFAULT = 10;

  // inverse of the hyperbolic gain for iterations 1..10 with 4 run twice
  localparam int GAIN_FRAC = 12;
  localparam logic [15:0] GAIN_INV = 16'd4946;  // ~1.2075

  // iterations 4, 13, 40, ... must run twice for the hyperbolic mode to converge
  function automatic bit is_repeat_iter(input int idx);
    int k;
    bit hit;
    k = 4;
    hit = 1'b0;
    while (k <= idx) begin
      if (k == idx) begin
        hit = 1'b1;
      end
      k = 3 * k + 1;
    end
    return hit;
  endfunction

  // one pipeline slot of 33 bits
  typedef struct packed {
    logic                valid;
    sqrt_fmt_pkg::work_t x;
    sqrt_fmt_pkg::work_t y;
  } cordic_beat_t;

endpackage

`default_nettype wire

// File: hdl/sqrt_fmt_pkg.sv
`default_nettype none

// fixed-point formats shared by the datapath and the testbench
package sqrt_fmt_pkg;

  // external word, unsigned, used for both the sample and the root
  localparam int IN_WIDTH = 8;
  localparam int IN_FRAC = 3;

  // internal word is twice as wide
  // leaves one sign bit and three integer bits above the fraction
  localparam int WORK_WIDTH = 2 * IN_WIDTH;
  localparam int WORK_FRAC = 12;

  typedef logic [IN_WIDTH-1:0] in_t;    // input sample
  typedef logic [IN_WIDTH-1:0] out_t;   // root in the same format as in_t

  typedef logic signed [WORK_WIDTH-1:0] work_t;  // x or y inside the CORDIC chain

endpackage

`default_nettype wire
